// ==== src/lcd_cmd_pkg.sv ====
`default_nettype none

package lcd_cmd_pkg;

	// bit order follows the 7-bit cfg input, msb first
	typedef struct packed {
		logic display_lines; // N bit, two-line mode
		logic font;          // F bit, 5x10 dots
		logic display_on;
		logic cursor;
		logic blink;
		logic inc_dec;       // I/D bit
		logic shift;         // S bit
	} lcd_config_t;

	// one word on the 10-bit host bus
	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_word_t;

	localparam logic [7:0] cmd_clear         = 8'h01;
	localparam logic [7:0] cmd_entry_mode    = 8'h04;
	localparam logic [7:0] cmd_display_ctrl  = 8'h08;
	localparam logic [7:0] cmd_function_set  = 8'h20;
	localparam logic [7:0] cmd_power_up_wake = cmd_function_set | 8'h10; // DL set, 8-bit bus

	// clear (0x01) and home (0x02/0x03) only use the two low bits
	localparam logic [7:0] long_cmd_mask = 8'hfc;

	// instruction words that need the long cycle
	function automatic logic is_long_cmd(lcd_word_t w);
		logic low_only;
		low_only = ((w.data & long_cmd_mask) == 8'h00);
		return !w.rs && low_only && (w.data != 8'h00);
	endfunction

endpackage

`default_nettype wire

// ==== src/lcd_timing_pkg.sv ====
`default_nettype none

package lcd_timing_pkg;

	// all durations in microseconds
	localparam int unsigned t_power_up_us    = 500;
	localparam int unsigned t_setup_us       = 1;   // e low before the pulse
	localparam int unsigned t_enable_high_us = 13;
	localparam int unsigned t_enable_low_us  = 13;
	localparam int unsigned t_cycle_us       = 50;  // ordinary word
	localparam int unsigned t_long_cycle_us  = 200; // clear and home

	// fastest clock supported, 200 MHz
	localparam int unsigned max_clk_cycles_per_us = 200;

	// power-up wait is the longest count anywhere
	localparam int unsigned cnt_width = $clog2(t_power_up_us * max_clk_cycles_per_us + 1);

endpackage

`default_nettype wire

// ==== src/lcd_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface lcd_bus_if;
	import lcd_cmd_pkg::*;

	logic      start; // one-cycle request with word
	lcd_word_t word;
	logic      done;  // last cycle of the bus cycle

	modport sequencer (
		output start,
		output word,
		input  done
	);

	modport cycle (
		input  start,
		input  word,
		output done
	);

endinterface

`default_nettype wire

// ==== src/lcd_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcd_sequencer #(
	parameter int unsigned clk_cycles_per_us = 50
) (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire lcd_cmd_pkg::lcd_config_t cfg,
	input  wire                      lcd_enable,
	input  wire lcd_cmd_pkg::lcd_word_t   lcd_bus,
	output logic                     busy,
	lcd_bus_if.sequencer             bus
);
	import lcd_cmd_pkg::*;
	import lcd_timing_pkg::*;

	localparam int unsigned power_up_cycles = t_power_up_us * clk_cycles_per_us;
	localparam logic [cnt_width-1:0] power_up_last = cnt_width'(power_up_cycles - 1);

	typedef enum logic [1:0] {
		power_up,
		init,
		ready,
		wait_done
	} state_t;

	state_t               state;
	logic [cnt_width-1:0] pu_cnt;   // power-up wait
	logic [1:0]           init_idx; // which init command, stays at 3 after init
	lcd_config_t          cfg_q;
	lcd_word_t            init_word;

	// init commands are instruction writes built from the sampled config
	always_comb begin
		init_word.rs = 1'b0;
		init_word.rw = 1'b0;
		case (init_idx)
			2'd0: begin
				init_word.data = cmd_power_up_wake
					| {4'b0000, cfg_q.display_lines, cfg_q.font, 2'b00};
			end
			2'd1: begin
				init_word.data = cmd_display_ctrl
					| {5'b00000, cfg_q.display_on, cfg_q.cursor, cfg_q.blink};
			end
			2'd2: begin
				init_word.data = cmd_clear;
			end
			default: begin
				init_word.data = cmd_entry_mode
					| {6'b000000, cfg_q.inc_dec, cfg_q.shift};
			end
		endcase
	end

	// no bus cycle runs in init or ready
	assign bus.start = (state == init) || ((state == ready) && lcd_enable);
	assign bus.word  = (state == init) ? init_word : lcd_bus;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= power_up;
			pu_cnt   <= '0;
			init_idx <= 2'd0;
			cfg_q    <= '0;
			busy     <= 1'b1;
		end else begin
			case (state)
				power_up: begin
					pu_cnt <= pu_cnt + 1'b1;
					if (pu_cnt == power_up_last) begin
						cfg_q <= cfg; // held for the whole init
						state <= init;
					end
				end
				init: begin
					state <= wait_done; // start went out this cycle
				end
				ready: begin
					if (lcd_enable) begin
						busy  <= 1'b1;
						state <= wait_done;
					end
				end
				default: begin
					if (bus.done) begin
						if (init_idx != 2'd3) begin
							init_idx <= init_idx + 2'd1;
							state    <= init;
						end else begin
							// last init word or a host word finished
							busy  <= 1'b0;
							state <= ready;
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/lcd_bus_cycle.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcd_bus_cycle #(
	parameter int unsigned clk_cycles_per_us = 50
) (
	input  wire        clk,
	input  wire        rst_n,
	lcd_bus_if.cycle   bus,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data
);
	import lcd_cmd_pkg::*;
	import lcd_timing_pkg::*;

	localparam int unsigned c = clk_cycles_per_us;

	// phase boundaries counted from the start edge
	localparam logic [cnt_width-1:0] setup_end = cnt_width'(t_setup_us * c);
	localparam logic [cnt_width-1:0] high_end =
		cnt_width'((t_setup_us + t_enable_high_us) * c);
	localparam logic [cnt_width-1:0] low_end =
		cnt_width'((t_setup_us + t_enable_high_us + t_enable_low_us) * c);
	localparam logic [cnt_width-1:0] short_last = cnt_width'(t_cycle_us * c - 1);
	localparam logic [cnt_width-1:0] long_last  = cnt_width'(t_long_cycle_us * c - 1);

	typedef enum logic [1:0] {
		ph_setup,
		ph_high,
		ph_low,
		ph_hold
	} phase_t;

	logic                 active;   // a bus cycle is running
	logic                 long_cyc; // clear or home in flight
	logic [cnt_width-1:0] cnt;
	logic [cnt_width-1:0] cnt_nxt;
	logic [cnt_width-1:0] last;
	phase_t               phase_nxt;

	always_comb begin
		cnt_nxt = cnt + 1'b1;
		if (cnt_nxt < setup_end) begin
			phase_nxt = ph_setup;
		end else if (cnt_nxt < high_end) begin
			phase_nxt = ph_high;
		end else if (cnt_nxt < low_end) begin
			phase_nxt = ph_low;
		end else begin
			phase_nxt = ph_hold;
		end
	end

	assign last     = long_cyc ? long_last : short_last;
	assign bus.done = active && (cnt == last);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active   <= 1'b0;
			long_cyc <= 1'b0;
			cnt      <= '0;
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= 8'h00;
		end else if (active) begin
			if (cnt == last) begin
				active   <= 1'b0;
				e        <= 1'b0;
				rs       <= 1'b0; // pins back to idle
				rw       <= 1'b0;
				lcd_data <= 8'h00;
			end else begin
				cnt <= cnt_nxt;
				e   <= (phase_nxt == ph_high);
			end
		end else if (bus.start) begin
			active   <= 1'b1;
			long_cyc <= is_long_cmd(bus.word);
			cnt      <= '0;
			e        <= 1'b0; // setup phase first
			rs       <= bus.word.rs;
			rw       <= bus.word.rw;
			lcd_data <= bus.word.data;
		end
	end

endmodule

`default_nettype wire

// ==== src/lcd_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcd_controller #(
	parameter int unsigned clk_cycles_per_us = 50
) (
	input  wire        clk,
	input  wire        rst_n,
	input  wire  [6:0] cfg,        // {lines, font, on, cursor, blink, inc_dec, shift}
	input  wire        lcd_enable,
	input  wire  [9:0] lcd_bus,    // {rs, rw, data}
	output logic       e,
	output logic [7:0] lcd_data,
	output logic       rw,
	output logic       rs,
	output logic       busy
);
	import lcd_cmd_pkg::*;

	lcd_config_t cfg_s;
	lcd_word_t   host_word;

	assign cfg_s     = lcd_config_t'(cfg);
	assign host_word = lcd_word_t'(lcd_bus);

	lcd_bus_if bus_if ();

	lcd_sequencer #(
		.clk_cycles_per_us(clk_cycles_per_us)
	) u_sequencer (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg_s),
		.lcd_enable(lcd_enable),
		.lcd_bus   (host_word),
		.busy      (busy),
		.bus       (bus_if.sequencer)
	);

	lcd_bus_cycle #(
		.clk_cycles_per_us(clk_cycles_per_us)
	) u_bus_cycle (
		.clk     (clk),
		.rst_n   (rst_n),
		.bus     (bus_if.cycle),
		.e       (e),
		.rs      (rs),
		.rw      (rw),
		.lcd_data(lcd_data)
	);

endmodule

`default_nettype wire

// ==== verif/lcd_controller_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcd_controller_chk #(
	parameter int unsigned clk_cycles_per_us = 50
) (
	input wire       clk,
	input wire       rst_n,
	input wire       active,
	input wire       e,
	input wire       rs,
	input wire       rw,
	input wire [7:0] lcd_data
);
	import lcd_timing_pkg::*;

	localparam int unsigned high_cycles = t_enable_high_us * clk_cycles_per_us;

	int unsigned high_len; // length of the current e-high run

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			high_len <= 0;
		end else if (e) begin
			high_len <= high_len + 1;
		end else begin
			high_len <= 0;
		end
	end

	e_only_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		!active |-> !e)
		else $error("e high with no bus cycle running");

	pins_stable_in_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		(e && $past(e)) |-> $stable({rs, rw, lcd_data}))
		else $error("rs, rw or lcd_data changed while e was high");

	enable_high_width: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(e) |-> (high_len == high_cycles))
		else $error("e high for %0d cycles instead of %0d", high_len, high_cycles);

endmodule

bind lcd_bus_cycle lcd_controller_chk #(
	.clk_cycles_per_us(clk_cycles_per_us)
) u_chk (
	.clk     (clk),
	.rst_n   (rst_n),
	.active  (active),
	.e       (e),
	.rs      (rs),
	.rw      (rw),
	.lcd_data(lcd_data)
);

`default_nettype wire

// ==== verif/lcd_controller_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcd_controller_tb;
	import lcd_timing_pkg::*;

	localparam int unsigned clk_cycles_per_us = 2;
	localparam int golden_depth = 48;

	// power-up wait plus four full init word cycles
	localparam int unsigned init_busy_min = (t_power_up_us + 4 * t_cycle_us) * clk_cycles_per_us;

	logic       clk;
	logic       rst_n;
	logic [6:0] cfg;
	logic       lcd_enable;
	logic [9:0] lcd_bus;
	wire        e;
	wire  [7:0] lcd_data;
	wire        rw;
	wire        rs;
	wire        busy;

	logic [15:0]     golden [0:golden_depth-1];
	logic [9:0]      cap_q[$];        // {rs, rw, lcd_data} at each fall of e
	int unsigned     busy_runs[$];    // length of each busy-high run
	int unsigned     busy_len  = 0;
	int unsigned     pulse_cnt = 0;   // rising edges of e
	logic            e_q;
	int              gaps [0:golden_depth-1];
	longint unsigned wd_cycles;
	logic            wd_armed  = 1'b0;
	int              err_cnt   = 0;
	int              test_pass = 0;
	int              test_fail = 0;
	logic [31:0]     rng;

	lcd_controller #(
		.clk_cycles_per_us(clk_cycles_per_us)
	) dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.lcd_enable(lcd_enable),
		.lcd_bus   (lcd_bus),
		.e         (e),
		.lcd_data  (lcd_data),
		.rw        (rw),
		.rs        (rs),
		.busy      (busy)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// pin monitor, sampled away from the driving edge
	always @(negedge clk) begin
		if (rst_n === 1'b1) begin
			if (e_q && !e) cap_q.push_back({rs, rw, lcd_data});
			if (!e_q && e) pulse_cnt++;
			if (busy) begin
				busy_len++;
			end else if (busy_len != 0) begin
				busy_runs.push_back(busy_len);
				busy_len = 0;
			end
		end
		e_q <= e;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// one-cycle lcd_enable strobe
	task automatic strobe_word(input logic [9:0] w);
		@(posedge clk);
		#1;
		lcd_bus    = w;
		lcd_enable = 1'b1;
		@(posedge clk);
		#1;
		lcd_enable = 1'b0;
	endtask

	// returns one cycle after busy is seen low, so the monitor has logged the run
	task automatic wait_not_busy();
		while (busy) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic report_test(input int num, input string name, input int err_start);
		if (err_cnt == err_start) begin
			test_pass++;
			$display("test %0d %s: ok", num, name);
		end else begin
			test_fail++;
			$display("test %0d %s: %0d errors", num, name, err_cnt - err_start);
		end
	endtask

	initial begin
		wait (wd_armed);
		#(wd_cycles * 10 * 2);
		$display("watchdog expired after %0d ns, the tests did not finish", wd_cycles * 20);
		$display("sim failed");
		$finish;
	end

	initial begin
		int         host_n;
		int         sent;
		int         i;
		int         j;
		int         k;
		int         err_start;
		bit         bad;
		logic [9:0] exp_w;
		rst_n      = 1'b0;
		cfg        = 7'h00;
		lcd_enable = 1'b0;
		lcd_bus    = 10'h000;
		$readmemh("verif/lcd_golden.hex", golden);
		cfg    = golden[0][6:0];
		host_n = int'(golden[5]);
		rng    = 32'ha3f7_5a6a;
		wd_cycles = longint'((t_power_up_us + 4 * t_cycle_us) * clk_cycles_per_us);
		for (i = 0; i < host_n; i++) begin
			rng     = xorshift32(rng);
			gaps[i] = 1 + int'(rng % 8);
			wd_cycles += longint'(golden[8 + 3 * i]) + longint'(gaps[i]);
		end
		wd_armed = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		err_start = err_cnt;
		if (e !== 1'b0 || rs !== 1'b0 || rw !== 1'b0 || lcd_data !== 8'h00) begin
			$display("[ERROR] after reset e=%h rs=%h rw=%h lcd_data=%h expected 0",
				e, rs, rw, lcd_data);
			err_cnt++;
		end
		if (busy !== 1'b1) begin
			$display("[ERROR] after reset busy: got %h expected 1", busy);
			err_cnt++;
		end
		bad = 1'b0;
		for (i = 0; i < t_power_up_us * clk_cycles_per_us - 4; i++) begin
			@(posedge clk);
			#1;
			if (!bad && (busy !== 1'b1 || e !== 1'b0)) begin
				$display("[ERROR] power-up cycle %0d busy=%h e=%h expected 1 and 0",
					i, busy, e);
				err_cnt++;
				bad = 1'b1;
			end
		end
		if (pulse_cnt != 0) begin
			$display("enable pulse seen during the power-up wait");
			err_cnt++;
		end
		report_test(1, "reset and power-up", err_start);

		err_start = err_cnt;
		wait_not_busy();
		if (cap_q.size() != 4) begin
			$display("init gave %0d enable pulses instead of 4", cap_q.size());
			err_cnt++;
		end else begin
			for (k = 0; k < 4; k++) begin
				if (cap_q[k] !== golden[1 + k][9:0]) begin
					$display("[ERROR] init word %0d rs/rw/lcd_data: got %h expected %h",
						k, cap_q[k], golden[1 + k][9:0]);
					err_cnt++;
				end
				if (cap_q[k][9:8] !== 2'b00) begin
					$display("[ERROR] init word %0d rs/rw: got %h expected 0",
						k, cap_q[k][9:8]);
					err_cnt++;
				end
			end
		end
		if (busy_runs.size() != 1) begin
			$display("busy dropped before the init sequence had finished");
			err_cnt++;
		end else if (busy_runs[0] < init_busy_min) begin
			$display("[ERROR] busy high cycles in power-up and init: got %h expected at least %h",
				busy_runs[0], init_busy_min);
			err_cnt++;
		end
		report_test(2, "init sequence", err_start);
		cap_q.delete();
		busy_runs.delete();
		pulse_cnt = 0;

		// flagged words are strobed inside the busy window of the word before
		sent = 0;
		i    = 0;
		while (i < host_n) begin
			repeat (gaps[i]) @(posedge clk);
			strobe_word(golden[6 + 3 * i][9:0]);
			sent++;
			j = i + 1;
			while (j < host_n && golden[6 + 3 * j][12]) begin
				repeat (2) @(posedge clk);
				strobe_word(golden[6 + 3 * j][9:0]);
				j++;
			end
			wait_not_busy();
			i = j;
		end

		err_start = err_cnt;
		k = 0;
		for (i = 0; i < host_n; i++) begin
			if (!golden[6 + 3 * i][12]) begin
				exp_w = golden[7 + 3 * i][9:0];
				if (k >= cap_q.size()) begin
					$display("host word %0d never appeared on the pins", i);
					err_cnt++;
				end else begin
					if (cap_q[k][9] !== exp_w[9]) begin
						$display("[ERROR] host word %0d rs: got %h expected %h",
							i, cap_q[k][9], exp_w[9]);
						err_cnt++;
					end
					if (cap_q[k][8] !== exp_w[8]) begin
						$display("[ERROR] host word %0d rw: got %h expected %h",
							i, cap_q[k][8], exp_w[8]);
						err_cnt++;
					end
					if (cap_q[k][7:0] !== exp_w[7:0]) begin
						$display("[ERROR] host word %0d lcd_data: got %h expected %h",
							i, cap_q[k][7:0], exp_w[7:0]);
						err_cnt++;
					end
				end
				k++;
			end
		end
		report_test(3, "host words", err_start);

		err_start = err_cnt;
		k = 0;
		for (i = 0; i < host_n; i++) begin
			if (!golden[6 + 3 * i][12]) begin
				if (k >= busy_runs.size()) begin
					$display("no busy period was seen for host word %0d", i);
					err_cnt++;
				end else if (busy_runs[k] != 32'(golden[8 + 3 * i])) begin
					$display("[ERROR] host word %0d busy high cycles: got %h expected %h",
						i, busy_runs[k], golden[8 + 3 * i]);
					err_cnt++;
				end
				k++;
			end
		end
		report_test(4, "cycle length", err_start);

		err_start = err_cnt;
		if (cap_q.size() != sent || pulse_cnt != sent || busy_runs.size() != sent) begin
			$display("%0d captures, %0d pulses and %0d busy periods for %0d accepted words",
				cap_q.size(), pulse_cnt, busy_runs.size(), sent);
			err_cnt++;
		end
		report_test(5, "back-pressure", err_start);

		$display("tests ok %0d, tests failing %0d", test_pass, test_fail);
		if (test_fail == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/lcd_golden.hex ====
// config word {lines, font, on, cursor, blink, inc_dec, shift}
005a
// expected init captures {rs, rw, lcd_data}: function set, display, clear, entry mode
0038 000e 0001 0006
// number of host entries
000d
// stimulus {flag bit 12 = send while busy, rs, rw, lcd_data}, expected capture,
// expected busy-high cycles at 2 clocks per us (0 for flagged words)
0241 0241 0064
1242 0000 0000
0001 0001 0190
024c 024c 0064
0002 0002 0190
1255 0000 0000
1003 0000 0000
0080 0080 0064
0343 0343 0064
0100 0100 0064
0003 0003 0190
000c 000c 0064
1241 0000 0000

// ==== char_lcd.f ====
src/lcd_cmd_pkg.sv
src/lcd_timing_pkg.sv
src/lcd_bus_if.sv
src/lcd_sequencer.sv
src/lcd_bus_cycle.sv
src/lcd_controller.sv
verif/lcd_controller_chk.sv
verif/lcd_controller_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the char_lcd testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator is not installed"
	exit 1
fi

verilator --binary -j 0 --assert -Wno-fatal --top-module lcd_controller_tb \
	-f char_lcd.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vlcd_controller_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
